// ==== vlog.f ====
csr_addr_pkg.sv
csr_reg_pkg.sv
csr_rw_pipe.sv
csr_regfile.sv
csr_irq.sv
csr_priv_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
();

    // the test sequence runs a few hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic             clk;
    logic             rst;
    logic             iss_en_i;
    csr_op_e          iss_op_i;
    logic [11:0]      iss_addr_i;
    logic [31:0]      iss_rs1_i;
    logic [4:0]       iss_imm_i;
    logic             iss_exc_valid_i;
    logic [4:0]       iss_exccode_i;
    logic             flush_i;
    logic             trap_en_i;
    logic [4:0]       trap_code_i;
    logic             trap_irq_i;
    logic [31:0]      exc_pc_i;
    logic [31:0]      exc_vaddr_i;
    logic [31:0]      trap_inst_i;
    logic             msip_i;
    logic             mtip_i;
    logic             meip_i;
    logic             wb_en_o;
    logic [31:0]      wb_data_o;
    logic [4:0]       wb_exc_o;
    logic [31:0]      target_pc_o;
    logic             irq_o;
    logic [4:0]       irq_code_o;

    // reference state
    logic [31:0]      ref_mscratch;
    logic [31:0]      ref_mtvec;
    logic [31:0]      ref_mepc;
    logic [31:0]      ref_mie;
    logic [1:0]       ref_mode;
    integer           seed;
    integer           cycles = 0;

    csr_unit #(.XLEN(32)) u_dut (
        .clk             (clk),
        .rst             (rst),
        .iss_en_i        (iss_en_i),
        .iss_op_i        (iss_op_i),
        .iss_addr_i      (iss_addr_i),
        .iss_rs1_i       (iss_rs1_i),
        .iss_imm_i       (iss_imm_i),
        .iss_exc_valid_i (iss_exc_valid_i),
        .iss_exccode_i   (iss_exccode_i),
        .flush_i         (flush_i),
        .trap_en_i       (trap_en_i),
        .trap_code_i     (trap_code_i),
        .trap_irq_i      (trap_irq_i),
        .exc_pc_i        (exc_pc_i),
        .exc_vaddr_i     (exc_vaddr_i),
        .trap_inst_i     (trap_inst_i),
        .msip_i          (msip_i),
        .mtip_i          (mtip_i),
        .meip_i          (meip_i),
        .wb_en_o         (wb_en_o),
        .wb_data_o       (wb_data_o),
        .wb_exc_o        (wb_exc_o),
        .target_pc_o     (target_pc_o),
        .irq_o           (irq_o),
        .irq_code_o      (irq_code_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [31:0] ref_value(input logic [11:0] addr);
        case (addr)
            ADDR_MSCRATCH: ref_value = ref_mscratch;
            ADDR_MTVEC:    ref_value = ref_mtvec;
            ADDR_MEPC:     ref_value = ref_mepc;
            default:       ref_value = ref_mie;
        endcase
    endfunction

    // warl rules on the reference side
    task automatic store_ref(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            ADDR_MSCRATCH: ref_mscratch = val;
            ADDR_MTVEC:    ref_mtvec = val & 32'hFFFF_FFFD;
            ADDR_MEPC:     ref_mepc = val & 32'hFFFF_FFFC;
            default:       ref_mie = val & 32'h0000_0888;
        endcase
    endtask

    // one issue cycle, result sampled late in that cycle
    task automatic do_csr(input csr_op_e op, input logic [11:0] addr, input logic [31:0] src,
                          output logic [31:0] rdata, output logic [4:0] exc);
        iss_en_i = 1'b1;
        iss_op_i = op;
        iss_addr_i = addr;
        iss_rs1_i = src;
        iss_imm_i = src[4:0];
        #2;
        check(wb_en_o, 32'd1, "wb_en_o");
        rdata = wb_data_o;
        exc = wb_exc_o;
        @(posedge clk);
        #1;
        iss_en_i = 1'b0;
        iss_op_i = CSR_NONE;
    endtask

    task automatic expect_csr(input logic [11:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rdata;
        logic [4:0]  exc;
        do_csr(CSR_RS, addr, 32'd0, rdata, exc);
        check(exc, EXC_NONE, what);
        check(rdata, exp, what);
    endtask

    task automatic write_csr(input csr_op_e op, input logic [11:0] addr, input logic [31:0] val);
        logic [31:0] rdata;
        logic [4:0]  exc;
        do_csr(op, addr, val, rdata, exc);
        check(exc, EXC_NONE, "write exception");
        idle(2);
    endtask

    task automatic rmw(input csr_op_e op, input logic [11:0] addr, input logic [31:0] src_in);
        logic [31:0] src;
        logic [31:0] old;
        logic [31:0] rdata;
        logic [4:0]  exc;
        src = op[2] ? {27'd0, src_in[4:0]} : src_in;
        old = ref_value(addr);
        do_csr(op, addr, src_in, rdata, exc);
        check(exc, EXC_NONE, "rmw exception");
        check(rdata, old, "rmw old value");
        case (op[1:0])
            2'b01:   store_ref(addr, src);
            2'b10:   store_ref(addr, old | src);
            default: store_ref(addr, old & ~src);
        endcase
        idle(2);
        expect_csr(addr, ref_value(addr), "rmw read back");
    endtask

    // mscratch is machine only, so the exception tells the mode
    task automatic check_mode(input string what);
        logic [31:0] rdata;
        logic [4:0]  exc;
        do_csr(CSR_RS, ADDR_MSCRATCH, 32'd0, rdata, exc);
        check(exc, (ref_mode == MODE_U) ? EXC_II : EXC_NONE, what);
    endtask

    task automatic take_trap(input logic [4:0] code, input logic irq, input logic [31:0] pc,
                             input logic [31:0] vaddr, input logic [31:0] exp_target);
        trap_en_i = 1'b1;
        trap_code_i = code;
        trap_irq_i = irq;
        exc_pc_i = pc;
        exc_vaddr_i = vaddr;
        #2;
        check(target_pc_o, exp_target, "target pc");
        @(posedge clk);
        #1;
        trap_en_i = 1'b0;
    endtask

    task automatic check_irq(input logic [4:0] code);
        #2;
        check(irq_o, 32'd1, "irq_o");
        check(irq_code_o, code, "irq_code_o");
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        check(wb_en_o, 32'd0, "wb_en_o while idle");
        check(irq_o, 32'd0, "irq_o after reset");
        expect_csr(ADDR_MSCRATCH, 32'd0, "mscratch after reset");
        expect_csr(ADDR_MISA, MISA_VALUE, "misa");
        expect_csr(ADDR_MSTATUS, 32'd0, "mstatus after reset");
        check_mode("mode after reset");
    endtask

    task automatic test_rmw();
        logic [31:0] rdata;
        logic [4:0]  exc;
        for (int i = 0; i < 4; i++) begin
            rmw(CSR_RW, ADDR_MSCRATCH, $random(seed));
            rmw(CSR_RS, ADDR_MSCRATCH, $random(seed));
            rmw(CSR_RC, ADDR_MSCRATCH, $random(seed));
            rmw(CSR_RWI, ADDR_MSCRATCH, $random(seed));
            rmw(CSR_RSI, ADDR_MSCRATCH, $random(seed));
            rmw(CSR_RCI, ADDR_MSCRATCH, $random(seed));
        end
        // zero immediate with rs1 set, a pure read even on a read-only csr
        do_csr(CSR_RSI, ADDR_MHARTID, 32'hFFFF_FFE0, rdata, exc);
        check(exc, EXC_NONE, "rsi zero on mhartid");
        rmw(CSR_RW, ADDR_MTVEC, 32'hFFFF_FFFF);
        rmw(CSR_RW, ADDR_MEPC, 32'hFFFF_FFFF);
        rmw(CSR_RW, ADDR_MEPC, $random(seed));
    endtask

    task automatic test_flush();
        logic [31:0] rdata;
        logic [4:0]  exc;
        // flush in the issue cycle itself
        flush_i = 1'b1;
        do_csr(CSR_RW, ADDR_MSCRATCH, ~ref_mscratch, rdata, exc);
        flush_i = 1'b0;
        idle(2);
        expect_csr(ADDR_MSCRATCH, ref_mscratch, "write flushed at issue");
        for (int d = 0; d < 2; d++) begin
            do_csr(CSR_RW, ADDR_MSCRATCH, ~ref_mscratch, rdata, exc);
            idle(d);
            flush_i = 1'b1;
            idle(1);
            flush_i = 1'b0;
            idle(2);
            expect_csr(ADDR_MSCRATCH, ref_mscratch, "flushed write");
        end
    endtask

    task automatic test_illegal();
        logic [31:0] rdata;
        logic [4:0]  exc;
        do_csr(CSR_RS, 12'h7C0, 32'd0, rdata, exc);
        check(exc, EXC_II, "unimplemented address");
        do_csr(CSR_RW, ADDR_MHARTID, 32'd5, rdata, exc);
        check(exc, EXC_II, "rw to mhartid");
        do_csr(CSR_RSI, ADDR_MHARTID, 32'd1, rdata, exc);
        check(exc, EXC_II, "rsi to mhartid");
        iss_exc_valid_i = 1'b1;
        iss_exccode_i = EXC_LAF;
        do_csr(CSR_RW, ADDR_MSCRATCH, ~ref_mscratch, rdata, exc);
        check(exc, EXC_LAF, "incoming exception");
        iss_exc_valid_i = 1'b0;
        idle(2);
        expect_csr(ADDR_MSCRATCH, ref_mscratch, "write with incoming exception");
    endtask

    task automatic test_traps();
        logic [31:0] rdata;
        logic [4:0]  exc;
        rmw(CSR_RW, ADDR_MTVEC, 32'h0000_1000);
        write_csr(CSR_RW, ADDR_MSTATUS, 32'h0000_0008);
        take_trap(EXC_II, 1'b0, 32'h0000_2004, 32'h55, ref_mtvec);
        ref_mepc = 32'h0000_2004;
        expect_csr(ADDR_MEPC, ref_mepc, "mepc on trap");
        expect_csr(ADDR_MCAUSE, 32'd2, "mcause on trap");
        expect_csr(ADDR_MTVAL, trap_inst_i, "mtval on trap");
        // mpie from mie, mpp = M
        expect_csr(ADDR_MSTATUS, 32'h0000_1880, "mstatus on trap");
        write_csr(CSR_RW, ADDR_MSTATUS, 32'h0000_0080);
        take_trap(EXC_MRET, 1'b0, 32'h0, 32'h0, ref_mepc);
        ref_mode = MODE_U;
        check_mode("mode after mret");
        do_csr(CSR_RW, ADDR_MSCRATCH, ~ref_mscratch, rdata, exc);
        check(exc, EXC_II, "user write to mscratch");
        take_trap(EXC_ECALL, 1'b0, 32'h0000_3000, 32'h0, ref_mtvec);
        ref_mode = MODE_M;
        ref_mepc = 32'h0000_3000;
        expect_csr(ADDR_MCAUSE, 32'd8, "ecall from user");
        expect_csr(ADDR_MTVAL, 32'd0, "mtval on ecall");
        expect_csr(ADDR_MSTATUS, 32'h0000_0080, "mstatus on ecall");
        expect_csr(ADDR_MSCRATCH, ref_mscratch, "mscratch after user write");
        take_trap(EXC_MRET, 1'b0, 32'h0, 32'h0, ref_mepc);
        ref_mode = MODE_U;
        check_mode("mode after second mret");
        take_trap(EXC_MRET, 1'b0, 32'h0000_3010, 32'h0, ref_mtvec);
        ref_mode = MODE_M;
        ref_mepc = 32'h0000_3010;
        expect_csr(ADDR_MCAUSE, EXC_II, "mret from user");
        expect_csr(ADDR_MTVAL, trap_inst_i, "mtval on mret from user");
        expect_csr(ADDR_MEPC, ref_mepc, "mepc on mret from user");
        expect_csr(ADDR_MSTATUS, 32'h0000_0080, "mstatus on mret from user");
    endtask

    task automatic test_irq();
        rmw(CSR_RW, ADDR_MIE, 32'hFFFF_FFFF);
        write_csr(CSR_RW, ADDR_MSTATUS, 32'h0000_0008);
        meip_i = 1'b1;
        // two synchronizer edges, then visible
        for (int i = 0; i < 2; i++) begin
            #2;
            check(irq_o, 32'd0, "irq_o before sync");
            @(posedge clk);
            #1;
        end
        check_irq(IRQ_MEI);
        mtip_i = 1'b1;
        msip_i = 1'b1;
        idle(2);
        check_irq(IRQ_MEI);
        expect_csr(ADDR_MIP, 32'h0000_0888, "mip");
        meip_i = 1'b0;
        idle(2);
        check_irq(IRQ_MTI);
        mtip_i = 1'b0;
        idle(2);
        check_irq(IRQ_MSI);
        meip_i = 1'b1;
        idle(2);
        rmw(CSR_RSI, ADDR_MTVEC, 32'd1);
        take_trap(IRQ_MEI, 1'b1, 32'h0000_4000, 32'h0,
                  {ref_mtvec[31:2], 2'b00} + 32'd4 * 32'd11);
        ref_mepc = 32'h0000_4000;
        check(irq_o, 32'd0, "irq_o masked after trap");
        expect_csr(ADDR_MCAUSE, 32'h8000_000B, "interrupt mcause");
        expect_csr(ADDR_MTVAL, 32'd0, "interrupt mtval");
        expect_csr(ADDR_MEPC, ref_mepc, "interrupt mepc");
        // exceptions ignore vectored mode
        take_trap(EXC_LAF, 1'b0, 32'h0000_5000, 32'h0000_7788, {ref_mtvec[31:2], 2'b00});
        expect_csr(ADDR_MTVAL, 32'h0000_7788, "load fault mtval");
        meip_i = 1'b0;
        msip_i = 1'b0;
    endtask

    initial begin
        seed = 32'he139_ff91;
        clk = 1'b0;
        rst = 1'b1;
        iss_en_i = 1'b0;
        iss_op_i = CSR_NONE;
        iss_addr_i = '0;
        iss_rs1_i = '0;
        iss_imm_i = '0;
        iss_exc_valid_i = 1'b0;
        iss_exccode_i = '0;
        flush_i = 1'b0;
        trap_en_i = 1'b0;
        trap_code_i = '0;
        trap_irq_i = 1'b0;
        exc_pc_i = '0;
        exc_vaddr_i = '0;
        trap_inst_i = 32'h3020_0073;
        msip_i = 1'b0;
        mtip_i = 1'b0;
        meip_i = 1'b0;
        ref_mscratch = '0;
        ref_mtvec = '0;
        ref_mepc = '0;
        ref_mie = '0;
        ref_mode = MODE_M;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_rmw();
        test_flush();
        test_illegal();
        test_traps();
        test_irq();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  iss_en_i,
    input  wire csr_op_e         iss_op_i,
    input  wire [CSR_ADDR_W-1:0] iss_addr_i,
    input  wire [XLEN-1:0]       iss_rs1_i,
    input  wire [4:0]            iss_imm_i,
    input  wire                  iss_exc_valid_i,
    input  wire [EXC_W-1:0]      iss_exccode_i,
    input  wire                  flush_i,
    input  wire                  trap_en_i,
    input  wire [EXC_W-1:0]      trap_code_i,
    input  wire                  trap_irq_i,
    input  wire [XLEN-1:0]       exc_pc_i,
    input  wire [XLEN-1:0]       exc_vaddr_i,
    input  wire [31:0]           trap_inst_i,
    input  wire                  msip_i,
    input  wire                  mtip_i,
    input  wire                  meip_i,
    output logic                 wb_en_o,
    output logic [XLEN-1:0]      wb_data_o,
    output logic [EXC_W-1:0]     wb_exc_o,
    output logic [XLEN-1:0]      target_pc_o,
    output logic                 irq_o,
    output logic [EXC_W-1:0]     irq_code_o
);

    logic [CSR_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;
    logic                  rd_hit;
    logic                  cm_we;
    logic [CSR_ADDR_W-1:0] cm_addr;
    logic [XLEN-1:0]       cm_data;
    logic                  trap_we;
    logic                  ret_we;
    logic [XLEN-1:0]       new_mepc;
    logic [XLEN-1:0]       new_mcause;
    logic [XLEN-1:0]       new_mtval;
    logic [1:0]            mode;
    mstatus_u              mstatus;
    logic [XLEN-1:0]       mtvec;
    logic [XLEN-1:0]       mepc;
    logic [XLEN-1:0]       mie;
    logic [XLEN-1:0]       mip;

    // result comes back in the issue cycle
    assign wb_en_o = iss_en_i;

    csr_rw_pipe #(.XLEN(XLEN)) u_rw_pipe (
        .clk             (clk),
        .rst             (rst),
        .iss_en_i        (iss_en_i),
        .iss_op_i        (iss_op_i),
        .iss_addr_i      (iss_addr_i),
        .iss_rs1_i       (iss_rs1_i),
        .iss_imm_i       (iss_imm_i),
        .iss_exc_valid_i (iss_exc_valid_i),
        .iss_exccode_i   (iss_exccode_i),
        .flush_i         (flush_i),
        .mode_i          (mode),
        .rd_data_i       (rd_data),
        .rd_hit_i        (rd_hit),
        .rd_addr_o       (rd_addr),
        .wb_data_o       (wb_data_o),
        .wb_exc_o        (wb_exc_o),
        .cm_we_o         (cm_we),
        .cm_addr_o       (cm_addr),
        .cm_data_o       (cm_data)
    );

    csr_regfile #(.XLEN(XLEN)) u_regfile (
        .clk          (clk),
        .rst          (rst),
        .rd_addr_i    (rd_addr),
        .cm_we_i      (cm_we),
        .cm_addr_i    (cm_addr),
        .cm_data_i    (cm_data),
        .trap_we_i    (trap_we),
        .ret_we_i     (ret_we),
        .new_mepc_i   (new_mepc),
        .new_mcause_i (new_mcause),
        .new_mtval_i  (new_mtval),
        .mode_i       (mode),
        .mip_i        (mip),
        .rd_data_o    (rd_data),
        .rd_hit_o     (rd_hit),
        .mstatus_o    (mstatus),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .mie_o        (mie)
    );

    csr_irq #(.XLEN(XLEN)) u_irq (
        .clk        (clk),
        .rst        (rst),
        .msip_i     (msip_i),
        .mtip_i     (mtip_i),
        .meip_i     (meip_i),
        .mie_i      (mie),
        .mstatus_i  (mstatus),
        .mode_i     (mode),
        .mip_o      (mip),
        .irq_o      (irq_o),
        .irq_code_o (irq_code_o)
    );

    csr_priv_ctrl #(.XLEN(XLEN)) u_priv_ctrl (
        .clk          (clk),
        .rst          (rst),
        .trap_en_i    (trap_en_i),
        .trap_code_i  (trap_code_i),
        .trap_irq_i   (trap_irq_i),
        .exc_pc_i     (exc_pc_i),
        .exc_vaddr_i  (exc_vaddr_i),
        .trap_inst_i  (trap_inst_i),
        .mstatus_i    (mstatus),
        .mtvec_i      (mtvec),
        .mepc_i       (mepc),
        .mode_o       (mode),
        .trap_we_o    (trap_we),
        .ret_we_o     (ret_we),
        .new_mepc_o   (new_mepc),
        .new_mcause_o (new_mcause),
        .new_mtval_o  (new_mtval),
        .target_pc_o  (target_pc_o)
    );

endmodule

`default_nettype wire

// ==== csr_priv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_priv_ctrl
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              trap_en_i,
    input  wire [EXC_W-1:0]  trap_code_i,
    input  wire              trap_irq_i,
    input  wire [XLEN-1:0]   exc_pc_i,
    input  wire [XLEN-1:0]   exc_vaddr_i,
    input  wire [31:0]       trap_inst_i,
    input  wire mstatus_u    mstatus_i,
    input  wire [XLEN-1:0]   mtvec_i,
    input  wire [XLEN-1:0]   mepc_i,
    output logic [1:0]       mode_o,
    output logic             trap_we_o,
    output logic             ret_we_o,
    output logic [XLEN-1:0]  new_mepc_o,
    output logic [XLEN-1:0]  new_mcause_o,
    output logic [XLEN-1:0]  new_mtval_o,
    output logic [XLEN-1:0]  target_pc_o
);

    logic [1:0]       mode_q;
    logic             is_ret;
    logic             ret_err;
    logic             ret_ok;
    logic [EXC_W-1:0] exccode;
    logic [XLEN-1:0]  base;

    assign is_ret  = ~trap_irq_i & (trap_code_i == EXC_MRET);
    // mret is only legal from machine mode
    assign ret_err = is_ret & (mode_q != MODE_M);
    assign ret_ok  = is_ret & ~ret_err;

    always_comb begin
        if (~trap_irq_i & (trap_code_i == EXC_ECALL)) begin
            exccode = EXC_ECALL + EXC_W'(mode_q);
        end else if (ret_err) begin
            exccode = EXC_II;
        end else begin
            exccode = trap_code_i;
        end
    end

    assign trap_we_o = trap_en_i & ~ret_ok;
    assign ret_we_o  = trap_en_i & ret_ok;

    assign new_mepc_o   = exc_pc_i;
    assign new_mcause_o = {trap_irq_i, {(XLEN-1-EXC_W){1'b0}}, exccode};

    always_comb begin
        new_mtval_o = '0;
        if (~trap_irq_i) begin
            case (exccode)
                EXC_II:                             new_mtval_o = XLEN'(trap_inst_i);
                EXC_IAM, EXC_IAF:                   new_mtval_o = exc_pc_i;
                EXC_LAM, EXC_LAF, EXC_SAM, EXC_SAF: new_mtval_o = exc_vaddr_i;
                default:                            new_mtval_o = '0;
            endcase
        end
    end

    assign base = {mtvec_i[XLEN-1:2], 2'b00};

    // vectored mode only applies to interrupts
    assign target_pc_o = ret_ok ? mepc_i :
                         (trap_irq_i & mtvec_i[0]) ? base + (XLEN'(exccode) << 2) : base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q <= MODE_M;
        end else if (trap_en_i) begin
            mode_q <= ret_ok ? mstatus_i.f.mpp : MODE_M;
        end
    end

    assign mode_o = mode_q;

endmodule

`default_nettype wire

// ==== csr_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_irq
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              msip_i,
    input  wire              mtip_i,
    input  wire              meip_i,
    input  wire [XLEN-1:0]   mie_i,
    input  wire mstatus_u    mstatus_i,
    input  wire [1:0]        mode_i,
    output logic [XLEN-1:0]  mip_o,
    output logic             irq_o,
    output logic [EXC_W-1:0] irq_code_o
);

    // {mei, mti, msi}
    logic [2:0]      sync1;
    logic [2:0]      sync2;
    logic [XLEN-1:0] pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= {meip_i, mtip_i, msip_i};
            sync2 <= sync1;
        end
    end

    always_comb begin
        mip_o          = '0;
        mip_o[IRQ_MSI] = sync2[0];
        mip_o[IRQ_MTI] = sync2[1];
        mip_o[IRQ_MEI] = sync2[2];
    end

    assign pend = mip_o & mie_i;

    // user mode is always interruptible
    assign irq_o = (|pend) & ((mode_i == MODE_U) | mstatus_i.f.mie);

    assign irq_code_o = pend[IRQ_MEI] ? IRQ_MEI :
                        pend[IRQ_MTI] ? IRQ_MTI :
                        pend[IRQ_MSI] ? IRQ_MSI : EXC_NONE;

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_addr_pkg::*;
    import csr_reg_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [CSR_ADDR_W-1:0] rd_addr_i,
    input  wire                  cm_we_i,
    input  wire [CSR_ADDR_W-1:0] cm_addr_i,
    input  wire [XLEN-1:0]       cm_data_i,
    input  wire                  trap_we_i,
    input  wire                  ret_we_i,
    input  wire [XLEN-1:0]       new_mepc_i,
    input  wire [XLEN-1:0]       new_mcause_i,
    input  wire [XLEN-1:0]       new_mtval_i,
    input  wire [1:0]            mode_i,
    input  wire [XLEN-1:0]       mip_i,
    output logic [XLEN-1:0]      rd_data_o,
    output logic                 rd_hit_o,
    output mstatus_u             mstatus_o,
    output logic [XLEN-1:0]      mtvec_o,
    output logic [XLEN-1:0]      mepc_o,
    output logic [XLEN-1:0]      mie_o
);

    mstatus_u        mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mie_q      <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            if (cm_we_i) begin
                case (cm_addr_i)
                    ADDR_MSTATUS:  mstatus_q.raw <= cm_data_i[31:0] & MSTATUS_MASK;
                    ADDR_MTVEC:    mtvec_q <= cm_data_i & MTVEC_MASK[XLEN-1:0];
                    ADDR_MIE:      mie_q <= cm_data_i & IE_MASK[XLEN-1:0];
                    ADDR_MSCRATCH: mscratch_q <= cm_data_i;
                    ADDR_MEPC:     mepc_q <= cm_data_i & EPC_MASK[XLEN-1:0];
                    ADDR_MCAUSE:   mcause_q <= cm_data_i;
                    ADDR_MTVAL:    mtval_q <= cm_data_i;
                    // misa, mhartid and mip bits are fixed or wired
                    default: ;
                endcase
            end
            // a trap in the same cycle wins over a committed write
            if (trap_we_i) begin
                mepc_q              <= new_mepc_i & EPC_MASK[XLEN-1:0];
                mcause_q            <= new_mcause_i;
                mtval_q             <= new_mtval_i;
                mstatus_q.f.mpie    <= mstatus_q.f.mie;
                mstatus_q.f.mie     <= 1'b0;
                mstatus_q.f.mpp     <= mode_i;
            end else if (ret_we_i) begin
                mstatus_q.f.mie     <= mstatus_q.f.mpie;
                mstatus_q.f.mpie    <= 1'b1;
                mstatus_q.f.mpp     <= MODE_U;
            end
        end
    end

    // read decode
    always_comb begin
        rd_hit_o  = 1'b1;
        rd_data_o = '0;
        case (rd_addr_i)
            ADDR_MISA:     rd_data_o = XLEN'(MISA_VALUE);
            ADDR_MHARTID:  rd_data_o = '0;
            ADDR_MSTATUS:  rd_data_o = XLEN'(mstatus_q.raw);
            ADDR_MTVEC:    rd_data_o = mtvec_q;
            ADDR_MIE:      rd_data_o = mie_q;
            ADDR_MIP:      rd_data_o = mip_i;
            ADDR_MSCRATCH: rd_data_o = mscratch_q;
            ADDR_MEPC:     rd_data_o = mepc_q;
            ADDR_MCAUSE:   rd_data_o = mcause_q;
            ADDR_MTVAL:    rd_data_o = mtval_q;
            default:       rd_hit_o = 1'b0;
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mie_o     = mie_q;

endmodule

`default_nettype wire

// ==== csr_rw_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_rw_pipe
    import csr_addr_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   iss_en_i,
    input  wire csr_op_e          iss_op_i,
    input  wire [CSR_ADDR_W-1:0]  iss_addr_i,
    input  wire [XLEN-1:0]        iss_rs1_i,
    input  wire [4:0]             iss_imm_i,
    input  wire                   iss_exc_valid_i,
    input  wire [EXC_W-1:0]       iss_exccode_i,
    input  wire                   flush_i,
    input  wire [1:0]             mode_i,
    input  wire [XLEN-1:0]        rd_data_i,
    input  wire                   rd_hit_i,
    output logic [CSR_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [EXC_W-1:0]      wb_exc_o,
    output logic                  cm_we_o,
    output logic [CSR_ADDR_W-1:0] cm_addr_o,
    output logic [XLEN-1:0]       cm_data_o
);

    logic                  is_csr;
    logic                  op_rw;
    logic [XLEN-1:0]       src;
    logic                  do_write;
    logic                  read_only;
    logic                  illegal;
    logic                  wr_ok;
    logic [XLEN-1:0]       wdata;
    logic                  s1_vld;
    logic                  s2_vld;
    logic [CSR_ADDR_W-1:0] s1_addr;
    logic [CSR_ADDR_W-1:0] s2_addr;
    logic [XLEN-1:0]       s1_data;
    logic [XLEN-1:0]       s2_data;

    assign is_csr = ~iss_op_i[3] & (iss_op_i[1:0] != 2'b00) & ~iss_exc_valid_i;
    assign op_rw  = iss_op_i[1:0] == 2'b01;
    assign src    = iss_op_i[2] ? XLEN'(iss_imm_i) : iss_rs1_i;

    // set or clear with a zero source is a pure read
    assign do_write = is_csr & ~(iss_op_i[1] & (src == '0));

    assign read_only = (iss_addr_i[11:10] == 2'b11) |
                       (op_rw & ((iss_addr_i == ADDR_MHARTID) | (iss_addr_i == ADDR_MISA)));

    assign illegal = is_csr & (~rd_hit_i | (iss_addr_i[9:8] > mode_i) | (do_write & read_only));
    assign wr_ok   = iss_en_i & ~flush_i & do_write & ~illegal;

    always_comb begin
        case (iss_op_i[1:0])
            2'b01:   wdata = src;
            2'b10:   wdata = rd_data_i | src;
            default: wdata = rd_data_i & ~src;
        endcase
    end

    assign rd_addr_o = iss_addr_i;
    assign wb_data_o = rd_data_i;
    assign wb_exc_o  = illegal ? EXC_II : iss_exc_valid_i ? iss_exccode_i : EXC_NONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= wr_ok;
            s2_vld <= s1_vld & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= iss_addr_i;
        s1_data <= wdata;
        s2_addr <= s1_addr;
        s2_data <= s1_data;
    end

    // last chance for a flush to kill the write
    assign cm_we_o   = s2_vld & ~flush_i;
    assign cm_addr_o = s2_addr;
    assign cm_data_o = s2_data;

endmodule

`default_nettype wire

// ==== csr_reg_pkg.sv ====
`default_nettype none

package csr_reg_pkg;

    typedef struct packed {
        logic [18:0] rsv_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsv_10_8;
        logic        mpie;
        logic [2:0]  rsv_6_4;
        logic        mie;
        logic [2:0]  rsv_2_0;
    } mstatus_fields_t;

    // raw word for csr access, fields for trap and return
    typedef union packed {
        logic [31:0]     raw;
        mstatus_fields_t f;
    } mstatus_u;

    // mie, mpie and mpp only
    localparam logic [31:0] MSTATUS_MASK = 32'h0000_1888;

    // sized for the widest xlen, cut down where used
    localparam logic [63:0] MTVEC_MASK = ~64'h2;
    localparam logic [63:0] EPC_MASK   = ~64'h3;
    localparam logic [63:0] IE_MASK    = 64'h888;

    // rv32, extensions i and u
    localparam logic [31:0] MISA_VALUE = 32'h4010_0100;

endpackage

`default_nettype wire

// ==== csr_addr_pkg.sv ====
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_ADDR_W = 12;

    // implemented machine csrs
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID  = 12'hF14;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;

    // bit 3 marks a non-csr op, bit 2 picks the immediate source
    typedef enum logic [3:0] {
        CSR_RW   = 4'b0001,
        CSR_RS   = 4'b0010,
        CSR_RC   = 4'b0011,
        CSR_RWI  = 4'b0101,
        CSR_RSI  = 4'b0110,
        CSR_RCI  = 4'b0111,
        CSR_NONE = 4'b1000
    } csr_op_e;

    localparam logic [1:0] MODE_U = 2'd0;
    localparam logic [1:0] MODE_M = 2'd3;

    localparam int EXC_W = 5;

    localparam logic [EXC_W-1:0] EXC_IAM   = 5'd0;
    localparam logic [EXC_W-1:0] EXC_IAF   = 5'd1;
    localparam logic [EXC_W-1:0] EXC_II    = 5'd2;
    localparam logic [EXC_W-1:0] EXC_LAM   = 5'd4;
    localparam logic [EXC_W-1:0] EXC_LAF   = 5'd5;
    localparam logic [EXC_W-1:0] EXC_SAM   = 5'd6;
    localparam logic [EXC_W-1:0] EXC_SAF   = 5'd7;
    localparam logic [EXC_W-1:0] EXC_ECALL = 5'd8;
    // not an architectural cause, requests a return
    localparam logic [EXC_W-1:0] EXC_MRET  = 5'd24;
    localparam logic [EXC_W-1:0] EXC_NONE  = 5'd31;

    localparam logic [EXC_W-1:0] IRQ_MSI = 5'd3;
    localparam logic [EXC_W-1:0] IRQ_MTI = 5'd7;
    localparam logic [EXC_W-1:0] IRQ_MEI = 5'd11;

endpackage

`default_nettype wire
